// File: pp_pkg.sv
package pp_pkg;

    // array geometry
    localparam int num_col = 3;
    // control bank 2c, immediate bank 2c+1
    localparam int num_bank = 2 * num_col;

    // word and address widths
    localparam int dwidth_data = 16;
    localparam int dwidth_rfadd = 5;
    // every table and the inbound buffer span the full address range
    localparam int num_entry_max = 2 ** dwidth_rfadd;

    // control word field widths
    localparam int dwidth_op = 3;
    localparam int dwidth_shamt = 4;

    // alu opcodes
    localparam logic [dwidth_op-1:0] op_add = 3'd0;
    localparam logic [dwidth_op-1:0] op_sub = 3'd1;
    localparam logic [dwidth_op-1:0] op_xor = 3'd2;
    localparam logic [dwidth_op-1:0] op_and = 3'd3;
    localparam logic [dwidth_op-1:0] op_pass = 3'd4;

    // loader fsm encoding
    localparam int dwidth_state = 3;
    localparam logic [dwidth_state-1:0] st_idle = 3'd0;
    // start seen high, waiting for the fall
    localparam logic [dwidth_state-1:0] st_hold = 3'd1;
    localparam logic [dwidth_state-1:0] st_config = 3'd2;
    localparam logic [dwidth_state-1:0] st_inbound = 3'd3;
    // one cycle, drives load_done
    localparam logic [dwidth_state-1:0] st_done = 3'd4;

    // control word, two views of the same 16 bits
    // top bit selects which view applies
    typedef union packed {
        struct packed {
            logic is_shift;
            logic [dwidth_op-1:0] op;
            logic [dwidth_data-dwidth_op-2:0] rsvd;
        } alu;
        struct packed {
            logic is_shift;
            // 1 = shift left, 0 = logical right
            logic left;
            logic [dwidth_shamt-1:0] amt;
            logic [dwidth_data-dwidth_shamt-3:0] rsvd;
        } shf;
    } ctrl_word_u;

endpackage

// File: load_sequencer.sv
module load_sequencer (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic [pp_pkg::dwidth_rfadd-1:0] num_entry_config,
    input  logic [pp_pkg::dwidth_rfadd-1:0] num_entry_inbound,
    output logic [pp_pkg::dwidth_rfadd-1:0] wr_add,
    output logic [pp_pkg::num_bank-1:0] bank_wr_en,
    output logic [pp_pkg::dwidth_rfadd-1:0] inbound_wr_add,
    output logic inbound_wr_en,
    output logic load_take,
    output logic load_done
);
    import pp_pkg::*;

    // load order, per column: control 0..N-1, then immediate 0..N-1
    // after the last column: inbound 0..M-1

    logic [dwidth_state-1:0] state;
    logic [dwidth_state-1:0] next_state;
    logic [dwidth_rfadd-1:0] cfg_last;
    logic [dwidth_rfadd-1:0] inb_last;
    logic cfg_wrap;
    logic cfg_end;
    logic inb_end;

    assign cfg_last = num_entry_config - 1'b1;
    assign inb_last = num_entry_inbound - 1'b1;

    // table address about to wrap
    assign cfg_wrap = (state == st_config) && (wr_add == cfg_last);
    // wrap on the last bank ends the config phase
    assign cfg_end = cfg_wrap && bank_wr_en[num_bank-1];
    assign inb_end = (state == st_inbound) && (inbound_wr_add == inb_last);

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (start) begin
                    next_state = st_hold;
                end
            end
            st_hold: begin
                // falling edge of start
                if (!start) begin
                    next_state = st_config;
                end
            end
            st_config: begin
                if (cfg_end) begin
                    next_state = st_inbound;
                end
            end
            st_inbound: begin
                if (inb_end) begin
                    next_state = st_done;
                end
            end
            st_done: begin
                next_state = st_idle;
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    // table address and one-hot bank select
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_add <= '0;
            bank_wr_en <= '0;
        end else if (state == st_hold && !start) begin
            wr_add <= '0;
            // first write goes to column 0 control
            bank_wr_en <= {{(num_bank-1){1'b0}}, 1'b1};
        end else if (cfg_wrap) begin
            wr_add <= '0;
            // top bank shifts out, leaving zero
            bank_wr_en <= bank_wr_en << 1;
        end else if (state == st_config) begin
            wr_add <= wr_add + 1'b1;
        end
    end

    // inbound address, starts at 0 on entry to st_inbound
    always_ff @(posedge clk) begin
        if (rst) begin
            inbound_wr_add <= '0;
        end else if (cfg_end) begin
            inbound_wr_add <= '0;
        end else if (state == st_inbound && !inb_end) begin
            inbound_wr_add <= inbound_wr_add + 1'b1;
        end
    end

    assign inbound_wr_en = (state == st_inbound);
    // host advances its word on every write
    assign load_take = (|bank_wr_en) | inbound_wr_en;
    assign load_done = (state == st_done);

endmodule

// File: table_store.sv
module table_store (
    input  logic clk,
    input  logic [pp_pkg::num_bank-1:0] bank_wr_en,
    input  logic [pp_pkg::dwidth_rfadd-1:0] wr_add,
    input  logic inbound_wr_en,
    input  logic [pp_pkg::dwidth_rfadd-1:0] inbound_wr_add,
    input  logic [pp_pkg::dwidth_data-1:0] load_data,
    input  logic [pp_pkg::dwidth_rfadd-1:0] rd_add,
    input  logic [pp_pkg::dwidth_rfadd-1:0] inbound_rd_add,
    output logic [pp_pkg::num_col-1:0][pp_pkg::dwidth_data-1:0] ctrl_rd,
    output logic [pp_pkg::num_col-1:0][pp_pkg::dwidth_data-1:0] imm_rd,
    output logic [pp_pkg::dwidth_data-1:0] inbound_rd
);
    import pp_pkg::*;

    // one control and one immediate table per column
    logic [dwidth_data-1:0] ctrl_mem [num_col][num_entry_max];
    logic [dwidth_data-1:0] imm_mem [num_col][num_entry_max];
    logic [dwidth_data-1:0] inbound_mem [num_entry_max];

    // table writes, even bank = control, odd bank = immediate
    always_ff @(posedge clk) begin
        for (int c = 0; c < num_col; c++) begin
            if (bank_wr_en[2*c]) begin
                ctrl_mem[c][wr_add] <= load_data;
            end
            if (bank_wr_en[2*c+1]) begin
                imm_mem[c][wr_add] <= load_data;
            end
        end
    end

    // all columns share the read address
    always_ff @(posedge clk) begin
        for (int c = 0; c < num_col; c++) begin
            ctrl_rd[c] <= ctrl_mem[c][rd_add];
            imm_rd[c] <= imm_mem[c][rd_add];
        end
    end

    // inbound buffer
    always_ff @(posedge clk) begin
        if (inbound_wr_en) begin
            inbound_mem[inbound_wr_add] <= load_data;
        end
    end

    // one cycle read latency, same as the tables
    always_ff @(posedge clk) begin
        inbound_rd <= inbound_mem[inbound_rd_add];
    end

endmodule

// File: entry_decode.sv
module entry_decode (
    input  logic clk,
    input  logic rst,
    input  logic run,
    input  logic [pp_pkg::dwidth_rfadd-1:0] num_entry_config,
    input  logic [pp_pkg::dwidth_rfadd-1:0] num_entry_inbound,
    input  logic [pp_pkg::num_col-1:0][pp_pkg::dwidth_data-1:0] ctrl_rd,
    input  logic [pp_pkg::num_col-1:0][pp_pkg::dwidth_data-1:0] imm_rd,
    input  logic [pp_pkg::dwidth_data-1:0] inbound_rd,
    output logic [pp_pkg::dwidth_rfadd-1:0] rd_add,
    output logic [pp_pkg::dwidth_rfadd-1:0] inbound_rd_add,
    output logic issue_valid,
    output logic [pp_pkg::num_col-1:0] is_shift,
    output logic [pp_pkg::num_col-1:0][pp_pkg::dwidth_op-1:0] op,
    output logic [pp_pkg::num_col-1:0] shift_left,
    output logic [pp_pkg::num_col-1:0][pp_pkg::dwidth_shamt-1:0] shift_amt,
    output logic [pp_pkg::num_col-1:0][pp_pkg::dwidth_data-1:0] imm,
    output logic [pp_pkg::dwidth_data-1:0] issue_data
);
    import pp_pkg::*;

    logic active;
    logic [dwidth_rfadd-1:0] cfg_last;
    logic [dwidth_rfadd-1:0] inb_last;
    ctrl_word_u cw [num_col];

    assign cfg_last = num_entry_config - 1'b1;
    assign inb_last = num_entry_inbound - 1'b1;

    // entry counter, table address runs modulo N
    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            rd_add <= '0;
            inbound_rd_add <= '0;
            issue_valid <= 1'b0;
        end else begin
            // read data lands one cycle after the address
            issue_valid <= active;
            if (!active) begin
                // run while busy never reaches here
                if (run) begin
                    active <= 1'b1;
                    rd_add <= '0;
                    inbound_rd_add <= '0;
                end
            end else if (inbound_rd_add == inb_last) begin
                active <= 1'b0;
            end else begin
                inbound_rd_add <= inbound_rd_add + 1'b1;
                rd_add <= (rd_add == cfg_last) ? '0 : rd_add + 1'b1;
            end
        end
    end

    // split each control word into alu and shift fields
    always_comb begin
        for (int c = 0; c < num_col; c++) begin
            cw[c] = ctrl_rd[c];
            is_shift[c] = cw[c].alu.is_shift;
            op[c] = cw[c].alu.op;
            shift_left[c] = cw[c].shf.left;
            shift_amt[c] = cw[c].shf.amt;
        end
    end

    assign imm = imm_rd;
    assign issue_data = inbound_rd;

endmodule

// File: column_execute.sv
module column_execute (
    input  logic clk,
    input  logic rst,
    input  logic issue_valid,
    input  logic [pp_pkg::dwidth_data-1:0] issue_data,
    input  logic [pp_pkg::num_col-1:0] is_shift,
    input  logic [pp_pkg::num_col-1:0][pp_pkg::dwidth_op-1:0] op,
    input  logic [pp_pkg::num_col-1:0] shift_left,
    input  logic [pp_pkg::num_col-1:0][pp_pkg::dwidth_shamt-1:0] shift_amt,
    input  logic [pp_pkg::num_col-1:0][pp_pkg::dwidth_data-1:0] imm,
    output logic out_valid,
    output logic [pp_pkg::dwidth_data-1:0] out_data
);
    import pp_pkg::*;

    // stage c holds the value after column c
    logic [num_col-1:0] valid_pipe;
    logic [dwidth_data-1:0] data_pipe [num_col];
    // controls of the columns still ahead ride with the value
    logic [num_col-1:0] shift_pipe [num_col-1];
    logic [num_col-1:0][dwidth_op-1:0] op_pipe [num_col-1];
    logic [num_col-1:0] left_pipe [num_col-1];
    logic [num_col-1:0][dwidth_shamt-1:0] amt_pipe [num_col-1];
    logic [num_col-1:0][dwidth_data-1:0] imm_pipe [num_col-1];

    // one column's operation, arithmetic wraps at 16 bits
    function automatic logic [dwidth_data-1:0] apply_op(
        input logic [dwidth_data-1:0] value,
        input logic shf,
        input logic [dwidth_op-1:0] opc,
        input logic left,
        input logic [dwidth_shamt-1:0] amt,
        input logic [dwidth_data-1:0] operand
    );
        logic [dwidth_data-1:0] res;
        if (shf) begin
            res = left ? (value << amt) : (value >> amt);
        end else begin
            case (opc)
                op_add:  res = value + operand;
                op_sub:  res = value - operand;
                op_xor:  res = value ^ operand;
                op_and:  res = value & operand;
                op_pass: res = value;
                // unused opcodes pass the value through
                default: res = value;
            endcase
        end
        return res;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[num_col-2:0], issue_valid};
        end
    end

    always_ff @(posedge clk) begin
        // column 0 works straight off the decoder
        data_pipe[0] <= apply_op(issue_data, is_shift[0], op[0], shift_left[0],
                                 shift_amt[0], imm[0]);
        shift_pipe[0] <= is_shift;
        op_pipe[0] <= op;
        left_pipe[0] <= shift_left;
        amt_pipe[0] <= shift_amt;
        imm_pipe[0] <= imm;
        // later columns use the controls captured with this entry
        for (int c = 1; c < num_col; c++) begin
            data_pipe[c] <= apply_op(data_pipe[c-1], shift_pipe[c-1][c], op_pipe[c-1][c],
                                     left_pipe[c-1][c], amt_pipe[c-1][c], imm_pipe[c-1][c]);
        end
        for (int c = 1; c < num_col - 1; c++) begin
            shift_pipe[c] <= shift_pipe[c-1];
            op_pipe[c] <= op_pipe[c-1];
            left_pipe[c] <= left_pipe[c-1];
            amt_pipe[c] <= amt_pipe[c-1];
            imm_pipe[c] <= imm_pipe[c-1];
        end
    end

    assign out_valid = valid_pipe[num_col-1];
    assign out_data = data_pipe[num_col-1];

endmodule

// File: result_collect.sv
module result_collect (
    input  logic clk,
    input  logic rst,
    input  logic out_valid,
    input  logic [pp_pkg::dwidth_data-1:0] out_data,
    input  logic [pp_pkg::dwidth_rfadd-1:0] num_entry_inbound,
    output logic result_valid,
    output logic [pp_pkg::dwidth_data-1:0] result_data,
    output logic run_done
);
    import pp_pkg::*;

    // results already presented in this run
    logic [dwidth_rfadd-1:0] res_count;
    logic last_result;

    // M-th result on the output this cycle
    assign last_result = result_valid && (res_count == num_entry_inbound - 1'b1);

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
            res_count <= '0;
            run_done <= 1'b0;
        end else begin
            result_valid <= out_valid;
            run_done <= last_result;
            if (last_result) begin
                // ready for the next run
                res_count <= '0;
            end else if (result_valid) begin
                res_count <= res_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        result_data <= out_data;
    end

endmodule

// File: pp_array_top.sv
module pp_array_top (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic [pp_pkg::dwidth_rfadd-1:0] num_entry_config,
    input  logic [pp_pkg::dwidth_rfadd-1:0] num_entry_inbound,
    input  logic [pp_pkg::dwidth_data-1:0] load_data,
    output logic load_take,
    output logic load_done,
    input  logic run,
    output logic result_valid,
    output logic [pp_pkg::dwidth_data-1:0] result_data,
    output logic run_done
);
    import pp_pkg::*;

    // loader to store
    logic [dwidth_rfadd-1:0] wr_add;
    logic [num_bank-1:0] bank_wr_en;
    logic [dwidth_rfadd-1:0] inbound_wr_add;
    logic inbound_wr_en;
    // decoder and store
    logic [dwidth_rfadd-1:0] rd_add;
    logic [dwidth_rfadd-1:0] inbound_rd_add;
    logic [num_col-1:0][dwidth_data-1:0] ctrl_rd;
    logic [num_col-1:0][dwidth_data-1:0] imm_rd;
    logic [dwidth_data-1:0] inbound_rd;
    // decoder to pipeline
    logic issue_valid;
    logic [dwidth_data-1:0] issue_data;
    logic [num_col-1:0] is_shift;
    logic [num_col-1:0][dwidth_op-1:0] op;
    logic [num_col-1:0] shift_left;
    logic [num_col-1:0][dwidth_shamt-1:0] shift_amt;
    logic [num_col-1:0][dwidth_data-1:0] imm;
    // pipeline to collector
    logic out_valid;
    logic [dwidth_data-1:0] out_data;

    load_sequencer u_load_sequencer (
        .clk               (clk),
        .rst               (rst),
        .start             (start),
        .num_entry_config  (num_entry_config),
        .num_entry_inbound (num_entry_inbound),
        .wr_add            (wr_add),
        .bank_wr_en        (bank_wr_en),
        .inbound_wr_add    (inbound_wr_add),
        .inbound_wr_en     (inbound_wr_en),
        .load_take         (load_take),
        .load_done         (load_done)
    );

    table_store u_table_store (
        .clk            (clk),
        .bank_wr_en     (bank_wr_en),
        .wr_add         (wr_add),
        .inbound_wr_en  (inbound_wr_en),
        .inbound_wr_add (inbound_wr_add),
        .load_data      (load_data),
        .rd_add         (rd_add),
        .inbound_rd_add (inbound_rd_add),
        .ctrl_rd        (ctrl_rd),
        .imm_rd         (imm_rd),
        .inbound_rd     (inbound_rd)
    );

    entry_decode u_entry_decode (
        .clk               (clk),
        .rst               (rst),
        .run               (run),
        .num_entry_config  (num_entry_config),
        .num_entry_inbound (num_entry_inbound),
        .ctrl_rd           (ctrl_rd),
        .imm_rd            (imm_rd),
        .inbound_rd        (inbound_rd),
        .rd_add            (rd_add),
        .inbound_rd_add    (inbound_rd_add),
        .issue_valid       (issue_valid),
        .is_shift          (is_shift),
        .op                (op),
        .shift_left        (shift_left),
        .shift_amt         (shift_amt),
        .imm               (imm),
        .issue_data        (issue_data)
    );

    column_execute u_column_execute (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_data  (issue_data),
        .is_shift    (is_shift),
        .op          (op),
        .shift_left  (shift_left),
        .shift_amt   (shift_amt),
        .imm         (imm),
        .out_valid   (out_valid),
        .out_data    (out_data)
    );

    result_collect u_result_collect (
        .clk               (clk),
        .rst               (rst),
        .out_valid         (out_valid),
        .out_data          (out_data),
        .num_entry_inbound (num_entry_inbound),
        .result_valid      (result_valid),
        .result_data       (result_data),
        .run_done          (run_done)
    );

endmodule

// File: pp_array_checker.sv
module pp_array_checker (
    input logic clk,
    input logic rst,
    input logic [pp_pkg::num_bank-1:0] bank_wr_en,
    input logic load_done,
    input logic run_done,
    input logic result_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    // failures so far, polled by the testbench
    int fail_count = 0;

    // at most one table bank takes a word per cycle
    bank_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(bank_wr_en))
        else begin
            fail_count++;
            $error("bank_wr_en has more than one bank set");
        end

    // outputs are cleared from the second reset edge on
    reset_quiet: assert property (@(posedge clk)
        (rst ##1 rst) |-> !(load_done || run_done || result_valid))
        else begin
            fail_count++;
            $error("done or valid output high during reset");
        end

    // load_done lasts one cycle
    load_done_pulse: assert property (@(posedge clk) disable iff (rst) load_done |=> !load_done)
        else begin
            fail_count++;
            $error("load_done held for more than one cycle");
        end

endmodule

bind pp_array_top pp_array_checker u_pp_array_checker (
    .clk          (clk),
    .rst          (rst),
    .bank_wr_en   (bank_wr_en),
    .load_done    (load_done),
    .run_done     (run_done),
    .result_valid (result_valid)
);

// File: tb_pp_array.sv
module tb_pp_array;
    timeunit 1ns;
    timeprecision 1ps;
    import pp_pkg::*;

    logic clk = 1'b0;
    logic rst;
    logic start;
    logic [dwidth_rfadd-1:0] num_entry_config;
    logic [dwidth_rfadd-1:0] num_entry_inbound;
    logic [dwidth_data-1:0] load_data;
    logic load_take;
    logic load_done;
    logic run;
    logic result_valid;
    logic [dwidth_data-1:0] result_data;
    logic run_done;

    // test storage, flat word queues with per-test offsets
    logic [dwidth_data-1:0] load_q[$];
    logic [dwidth_data-1:0] inb_q[$];
    logic [dwidth_data-1:0] exp_q[$];
    int n_q[$];
    int m_q[$];
    int load_base[$];
    int inb_base[$];
    int budget_cycles = 0;
    integer seed = 41514;

    always #50 clk = ~clk;

    pp_array_top u_pp_array_top (
        .clk               (clk),
        .rst               (rst),
        .start             (start),
        .num_entry_config  (num_entry_config),
        .num_entry_inbound (num_entry_inbound),
        .load_data         (load_data),
        .load_take         (load_take),
        .load_done         (load_done),
        .run               (run),
        .result_valid      (result_valid),
        .result_data       (result_data),
        .run_done          (run_done)
    );

    task automatic check_data(input logic [dwidth_data-1:0] got,
                              input logic [dwidth_data-1:0] exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s, got %h expected %h", $time, what, got, exp);
            $display("sim failed");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_pulse(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s, got %b expected %b", $time, what, got, exp);
            $display("sim failed");
            $fatal(1, "pulse mismatch");
        end
    endtask

    // one column, seen through both views of the control word
    function automatic logic [dwidth_data-1:0] column_rule(
        input logic [dwidth_data-1:0] value,
        input ctrl_word_u cw,
        input logic [dwidth_data-1:0] operand
    );
        logic [dwidth_data-1:0] res;
        // pass and unlisted opcodes keep the value
        res = value;
        if (cw.shf.is_shift && cw.shf.left) begin
            res = value << cw.shf.amt;
        end else if (cw.shf.is_shift) begin
            res = value >> cw.shf.amt;
        end else if (cw.alu.op == op_add) begin
            res = value + operand;
        end else if (cw.alu.op == op_sub) begin
            res = value - operand;
        end else if (cw.alu.op == op_xor) begin
            res = value ^ operand;
        end else if (cw.alu.op == op_and) begin
            res = value & operand;
        end
        return res;
    endfunction

    // entry k walks all columns at table address k mod N
    function automatic logic [dwidth_data-1:0] entry_rule(input int lbase, input int n,
                                                          input int k,
                                                          input logic [dwidth_data-1:0] value);
        logic [dwidth_data-1:0] v;
        int add;
        v = value;
        add = k % n;
        for (int c = 0; c < num_col; c++) begin
            v = column_rule(v, load_q[lbase + 2*c*n + add], load_q[lbase + 2*c*n + n + add]);
        end
        return v;
    endfunction

    task automatic read_word(input int fd, output logic [dwidth_data-1:0] w);
        int r;
        r = $fscanf(fd, "%h", w);
        if (r != 1) begin
            $display("the test file ends in the middle of a test");
            $display("sim failed");
            $fatal(1, "truncated test file");
        end
    endtask

    task automatic read_tests();
        int fd;
        int r;
        int n;
        int m;
        int rnd;
        int total;
        logic [dwidth_data-1:0] w;
        logic [dwidth_data-1:0] model;
        logic [8*256-1:0] line;
        fd = $fopen("pp_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open pp_tests.txt");
            $display("sim failed");
            $fatal(1, "missing test file");
        end
        // two comment lines name the columns
        r = $fgets(line, fd);
        r = $fgets(line, fd);
        total = 200;
        r = $fscanf(fd, "%d %d %d", n, m, rnd);
        while (r == 3) begin
            n_q.push_back(n);
            m_q.push_back(m);
            load_base.push_back(load_q.size());
            inb_base.push_back(inb_q.size());
            for (int i = 0; i < 6 * n; i++) begin
                read_word(fd, w);
                load_q.push_back(w);
            end
            for (int k = 0; k < m; k++) begin
                if (rnd != 0) begin
                    w = dwidth_data'($random(seed));
                end else begin
                    read_word(fd, w);
                end
                inb_q.push_back(w);
            end
            // file results must agree with the rule
            for (int k = 0; k < m; k++) begin
                model = entry_rule(load_base[$], n, k, inb_q[inb_base[$] + k]);
                exp_q.push_back(model);
                if (rnd == 0) begin
                    read_word(fd, w);
                    check_data(model, w,
                               $sformatf("rule for test %0d entry %0d", n_q.size() - 1, k));
                end
            end
            total += 6 * n + 2 * m + 20;
            r = $fscanf(fd, "%d %d %d", n, m, rnd);
        end
        $fclose(fd);
        budget_cycles = total;
    endtask

    task automatic load_tables(input int t);
        int n;
        int total;
        n = n_q[t];
        total = 6 * n + m_q[t];
        num_entry_config = dwidth_rfadd'(n);
        num_entry_inbound = dwidth_rfadd'(m_q[t]);
        start = 1'b1;
        @(negedge clk);
        // no write while start is still high
        check_pulse(load_take, 1'b0, "load_take before the start fall");
        start = 1'b0;
        @(negedge clk);
        // one word per cycle, no gaps
        for (int i = 0; i < total; i++) begin
            check_pulse(load_take, 1'b1, $sformatf("load_take at write %0d of test %0d", i, t));
            check_pulse(load_done, 1'b0, "load_done during the write phase");
            if (i < 6 * n) begin
                load_data = load_q[load_base[t] + i];
            end else begin
                load_data = inb_q[inb_base[t] + i - 6 * n];
            end
            // a start while loading is ignored
            start = (i == 2);
            @(negedge clk);
        end
        check_pulse(load_take, 1'b0, "load_take after the last write");
        check_pulse(load_done, 1'b1, "load_done after the last write");
        @(negedge clk);
        check_pulse(load_done, 1'b0, "load_done one cycle later");
    endtask

    task automatic run_entries(input int t);
        int m;
        int lat;
        int ridx;
        m = m_q[t];
        // counter, table read, then num_col stages and the collector
        lat = num_col + 3;
        run = 1'b1;
        for (int cyc = 1; cyc <= lat + m + 1; cyc++) begin
            @(negedge clk);
            // second run while busy, must not restart the walk
            run = (cyc == 2 && m >= 2);
            ridx = cyc - lat;
            if (ridx >= 0 && ridx < m) begin
                check_pulse(result_valid, 1'b1, $sformatf("result_valid, test %0d", t));
                check_data(result_data, exp_q[inb_base[t] + ridx],
                           $sformatf("result %0d of test %0d", ridx, t));
            end else begin
                check_pulse(result_valid, 1'b0, $sformatf("result_valid idle, test %0d", t));
            end
            check_pulse(run_done, ridx == m, $sformatf("run_done, test %0d", t));
        end
    endtask

    // protocol assertion failures end the run at once
    always @(negedge clk) begin
        if (u_pp_array_top.u_pp_array_checker.fail_count != 0) begin
            $display("a protocol assertion in the bound checker failed");
            $display("sim failed");
            $fatal(1, "protocol check failed");
        end
    end

    initial begin : watchdog
        wait (budget_cycles != 0);
        repeat (budget_cycles) @(posedge clk);
        $display("the run timed out after %0d cycles", budget_cycles);
        $display("sim failed");
        $fatal(1, "timeout");
    end

    initial begin : main_flow
        rst = 1'b1;
        start = 1'b0;
        run = 1'b0;
        load_data = '0;
        num_entry_config = 5'd1;
        num_entry_inbound = 5'd1;
        read_tests();
        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_pulse(load_take, 1'b0, "load_take after reset");
        check_pulse(load_done, 1'b0, "load_done after reset");
        check_pulse(result_valid, 1'b0, "result_valid after reset");
        check_pulse(run_done, 1'b0, "run_done after reset");
        // each test reloads the tables with its own N and M
        for (int t = 0; t < n_q.size(); t++) begin
            load_tables(t);
            run_entries(t);
        end
        if (u_pp_array_top.u_pp_array_checker.fail_count != 0) begin
            $display("the bound checker reported a protocol error");
            $display("sim failed");
            $fatal(1, "protocol check failed");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

// File: pp_tests.txt
# test header: N M R (R=1 draws the inbound words at random and gives no inbound or result lines)
# then per column N control and N immediate words, M inbound words, M results, all hex
3 3 0
0000 1000 2000  1234 0001 5555
2000 3000 7000  FFFF 0F0F 1111
4000 0000 1000  AAAA 8000 0003
F000 0000 00FF
FDCB 8F0F 55A7

3 3 0
C400 BC00 0000  DEAD 0000 0100
8C00 2000 FC00  0000 00FF 0000
1000 C000 A000  0010 0000 0000
8421 FFFF 0001
00F8 00FE 0080

2 5 0
0000 D000  0001 0000
2000 8400  00F0 0000
3000 4000  00FF 1234
0010 0123 00FF 0F00 FFFF
00E1 0918 00F0 7800 00F0

1 4 1
1000  0101
E000  0000
2000  5A5A

3 7 1
0000 8C00 3000  7777 0000 FF00
C400 1000 4000  0000 0042 0000
BC00 2000 0000  0000 FFFF 0001

1 1 0
0000  0005
1000  0007
C400  0000
0003
0002

// File: project.f
pp_pkg.sv
load_sequencer.sv
table_store.sv
entry_decode.sv
column_execute.sv
result_collect.sv
pp_array_top.sv
pp_array_checker.sv
tb_pp_array.sv

// File: Bender.yml
package:
  name: pp_array

sources:
  - pp_pkg.sv
  - load_sequencer.sv
  - table_store.sv
  - entry_decode.sv
  - column_execute.sv
  - result_collect.sv
  - pp_array_top.sv
  - target: test
    files:
      - pp_array_checker.sv
      - tb_pp_array.sv
